// File: files.f
src/soc_pkg.sv
src/id_remap.sv
src/soc_bus.sv
src/l2_mem.sv
src/cluster_unit.sv
src/soc_top.sv
tests/soc_checker.sv
tests/soc_tb.sv

// File: run.sh
#!/bin/sh
# build the soc_top testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --top-module soc_tb -f files.f -o soc_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/soc_sim > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "Checks failed" "$LOG"; then
  echo "simulation FAILED"
  exit 1
fi
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi
echo "simulation PASSED"
exit 0

// File: tests/soc_tb.sv
/*
 * soc_tb: clock, reset, stimulus table and shadow reference model
 * checks response data, error, host ID and cluster run length
 */

`timescale 1ns/1ps

module soc_tb;

  typedef enum logic [1:0] {OP_WR, OP_RD, OP_START} op_e;

  typedef struct packed {
    op_e                           op;
    logic [soc_pkg::ADDR_W-1:0]    addr;
    logic [soc_pkg::DATA_W-1:0]    wdata;
    logic [soc_pkg::HOST_ID_W-1:0] id;
    logic                          exp_err;
    logic [soc_pkg::DATA_W-1:0]    exp_rdata;
  } stim_t;

  logic                           clk;
  logic                           rst;
  soc_pkg::host_req_t             host_req;
  soc_pkg::host_resp_t            host_resp;
  logic [soc_pkg::N_CLUSTERS-1:0] fetch_en;
  logic [soc_pkg::N_CLUSTERS-1:0] busy;
  logic [soc_pkg::N_CLUSTERS-1:0] eoc;
  logic [15:0]                    lfsr_q;
  stim_t                          stim_tab[$];
  stim_t                          exp_q[$];
  // shadow state of the reference model
  logic [soc_pkg::DATA_W-1:0]     sh_l2 [soc_pkg::L2_WORDS];
  logic [15:0]                    sh_work_len [soc_pkg::N_CLUSTERS];
  logic [1:0]                     sh_status [soc_pkg::N_CLUSTERS];

  soc_top dut0 (
    .clk_i         (clk),
    .rst_i         (rst),
    .host_req_i    (host_req),
    .host_resp_o   (host_resp),
    .cl_fetch_en_i (fetch_en),
    .cl_busy_o     (busy),
    .cl_eoc_o      (eoc)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Fibonacci LFSR with taps at bits 16 14 13 11
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
      lfsr_q = {lfsr_q[14:0], fb};
      r      = {r[30:0], fb};
    end
    return r;
  endfunction

  task automatic fail_now();
    $display("Checks failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] got);
    assert (got === exp) else begin
      $display("ERROR time=%0t %s expected=0x%0h actual=0x%0h", $time, name, exp, got);
      fail_now();
    end
  endtask

  // expected response per entry, taken from the address map rules
  task automatic add_entry(input op_e op, input logic [15:0] addr, input logic [31:0] wdata);
    stim_t s;
    logic  c;
    s = '{op: op, addr: addr, wdata: wdata, id: 8'(rand_bits(8)),
          exp_err: 1'b0, exp_rdata: '0};
    c = addr[4];
    if (op == OP_START) begin
      s.wdata      = (sh_work_len[c] == 16'd0) ? 32'd1 : {16'd0, sh_work_len[c]};
      s.exp_rdata  = 32'd1;
      sh_status[c] = 2'b10;
    end else if (addr <= 16'h03FF) begin
      if (op == OP_WR) sh_l2[addr[9:2]] = wdata;
      else s.exp_rdata = sh_l2[addr[9:2]];
    end else if (addr[15:5] == 11'h080 && addr[3:2] == 2'd0) begin
      if (op == OP_WR) sh_work_len[c] = wdata[15:0];
      else s.exp_rdata = {16'd0, sh_work_len[c]};
    end else if (addr[15:5] == 11'h080 && addr[3:2] == 2'd1) begin
      // writes to STATUS are dropped
      if (op == OP_RD) s.exp_rdata = {30'd0, sh_status[c]};
    end else begin
      s.exp_err = 1'b1;
    end
    stim_tab.push_back(s);
  endtask

  task automatic build_table();
    logic [15:0] l2_addr [8];
    for (int i = 0; i < 8; i++) begin
      l2_addr[i] = {6'd0, 8'(rand_bits(8)), 2'd0};
      add_entry(OP_WR, l2_addr[i], rand_bits(32));
    end
    for (int i = 0; i < 8; i++) add_entry(OP_RD, l2_addr[i], 32'd0);
    add_entry(OP_WR, 16'h0000, rand_bits(32));
    // unmapped space and reserved cluster offsets
    add_entry(OP_WR, 16'h2000, rand_bits(32));
    add_entry(OP_RD, 16'h2000, 32'd0);
    add_entry(OP_RD, 16'h0400, 32'd0);
    add_entry(OP_WR, 16'h100C, 32'd3);
    add_entry(OP_RD, 16'h101C, 32'd0);
    add_entry(OP_RD, 16'h0000, 32'd0);
    add_entry(OP_RD, 16'h1000, 32'd0);
    // separate WORK_LEN per cluster
    add_entry(OP_WR, 16'h1000, 32'd6);
    add_entry(OP_WR, 16'h1010, 32'd9);
    add_entry(OP_RD, 16'h1000, 32'd0);
    add_entry(OP_RD, 16'h1010, 32'd0);
    add_entry(OP_WR, 16'h1004, 32'hFFFF);
    add_entry(OP_RD, 16'h1004, 32'd0);
    add_entry(OP_START, 16'h1004, 32'd0);
    add_entry(OP_RD, 16'h1004, 32'd0);
    add_entry(OP_RD, 16'h1014, 32'd0);
    add_entry(OP_START, 16'h1014, 32'd0);
    add_entry(OP_RD, 16'h1014, 32'd0);
    add_entry(OP_RD, 16'h1004, 32'd0);
    // zero length runs for one cycle
    add_entry(OP_WR, 16'h1000, 32'd0);
    add_entry(OP_START, 16'h1004, 32'd0);
    add_entry(OP_RD, 16'h1000, 32'd0);
  endtask

  // one cycle on the falling edge, checking any response in order
  task automatic next_cycle();
    stim_t e;
    @(negedge clk);
    host_req.valid = 1'b0;
    if (host_resp.valid) begin
      assert (exp_q.size() != 0) else begin
        $display("response arrived with no request outstanding");
        fail_now();
      end
      e = exp_q.pop_front();
      check_value("host_resp_o.id", 32'(e.id), 32'(host_resp.id));
      check_value("host_resp_o.err", 32'(e.exp_err), 32'(host_resp.err));
      check_value("host_resp_o.rdata", e.exp_rdata, host_resp.rdata);
    end
  endtask

  task automatic send_req(input stim_t s);
    next_cycle();
    host_req.valid = 1'b1;
    host_req.we    = (s.op == OP_WR);
    host_req.addr  = s.addr;
    host_req.wdata = s.wdata;
    host_req.id    = s.id;
    exp_q.push_back(s);
  endtask

  task automatic drain_responses();
    int waited;
    int left;
    waited = 0;
    while (exp_q.size() != 0) begin
      left = exp_q.size();
      next_cycle();
      waited = (exp_q.size() == left) ? waited + 1 : 0;
      assert (waited < 10) else begin
        $display("no response within 10 cycles, %0d requests outstanding", exp_q.size());
        fail_now();
      end
    end
  endtask

  task automatic run_cluster(input stim_t s);
    logic                           c;
    logic [soc_pkg::N_CLUSTERS-1:0] others;
    int                             busy_cycles;
    int                             waited;
    c           = s.addr[4];
    busy_cycles = 0;
    waited      = 0;
    drain_responses();
    // raise fetch enable and read STATUS in the same cycle
    send_req(s);
    fetch_en[c] = 1'b1;
    do begin
      next_cycle();
      waited++;
      assert (waited <= int'(s.wdata) + 10) else begin
        $display("cluster %0d did not reach end of computation in time", c);
        fail_now();
      end
      others    = busy;
      others[c] = 1'b0;
      check_value("cl_busy_o of idle cluster", 32'd0, 32'(others));
      if (busy[c]) begin
        busy_cycles++;
      end else begin
        // eoc rises in the cycle busy falls
        check_value("cl_eoc_o", 32'd1, 32'(eoc[c]));
      end
    end while (!eoc[c]);
    check_value("cl_busy_o cycle count", s.wdata, 32'(busy_cycles));
    fetch_en[c] = 1'b0;
    drain_responses();
  endtask

  initial begin
    rst      = 1'b1;
    host_req = '0;
    fetch_en = '0;
    lfsr_q   = 16'd40;
    for (int i = 0; i < soc_pkg::N_CLUSTERS; i++) begin
      sh_work_len[i] = 16'd1;
      sh_status[i]   = 2'b00;
    end
    build_table();
    repeat (16) @(negedge clk);
    rst = 1'b0;
    // bus entries go out back to back
    foreach (stim_tab[i]) begin
      if (stim_tab[i].op == OP_START) begin
        run_cluster(stim_tab[i]);
      end else begin
        send_req(stim_tab[i]);
      end
    end
    drain_responses();
    $display("All checks passed");
    $finish;
  end

endmodule

// File: tests/soc_checker.sv
/*
 * soc_checker: latency, busy/eoc exclusivity and reset assertions
 * bound into every soc_top instance
 */

`timescale 1ns/1ps

module soc_checker (
  input logic                           clk_i,
  input logic                           rst_i,
  input soc_pkg::host_req_t             host_req_i,
  input soc_pkg::host_resp_t            host_resp_i,
  input logic [soc_pkg::N_CLUSTERS-1:0] cl_busy_i,
  input logic [soc_pkg::N_CLUSTERS-1:0] cl_eoc_i
);

  // fixed three-cycle path, so nothing is ever dropped or stalled
  a_req_gets_resp: assert property (@(posedge clk_i) disable iff (rst_i)
    host_req_i.valid |-> ##3 host_resp_i.valid)
    else $error("request got no response three cycles later");

  a_resp_has_req: assert property (@(posedge clk_i) disable iff (rst_i)
    host_resp_i.valid |-> $past(host_req_i.valid, 3))
    else $error("response without a request three cycles earlier");

  a_busy_eoc_excl: assert property (@(posedge clk_i) disable iff (rst_i)
    (cl_busy_i & cl_eoc_i) == '0)
    else $error("busy and eoc high together on a cluster");

  // first reset edge only clears the registers
  a_reset_quiet: assert property (@(posedge clk_i)
    rst_i && $past(rst_i) |-> !host_resp_i.valid && cl_busy_i == '0 && cl_eoc_i == '0)
    else $error("outputs active during reset");

endmodule

bind soc_top soc_checker chk0 (
  .clk_i       (clk_i),
  .rst_i       (rst_i),
  .host_req_i  (host_req_i),
  .host_resp_i (host_resp_o),
  .cl_busy_i   (cl_busy_o),
  .cl_eoc_i    (cl_eoc_o)
);

// File: src/soc_top.sv
/*
 * soc_top: host ID remapper, SoC bus, L2 and the cluster units
 */

`timescale 1ns/1ps

module soc_top (
  input  logic                           clk_i,
  input  logic                           rst_i,
  input  soc_pkg::host_req_t             host_req_i,
  output soc_pkg::host_resp_t            host_resp_o,
  input  logic [soc_pkg::N_CLUSTERS-1:0] cl_fetch_en_i,
  output logic [soc_pkg::N_CLUSTERS-1:0] cl_busy_o,
  output logic [soc_pkg::N_CLUSTERS-1:0] cl_eoc_o
);

  soc_pkg::int_req_t                             int_req;
  soc_pkg::int_resp_t                            int_resp;
  soc_pkg::int_req_t                             l2_req;
  soc_pkg::int_resp_t                            l2_resp;
  soc_pkg::int_req_t  [soc_pkg::N_CLUSTERS-1:0]  cl_req;
  soc_pkg::int_resp_t [soc_pkg::N_CLUSTERS-1:0]  cl_resp;

  id_remap i_id_remap (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .host_req_i  (host_req_i),
    .host_resp_o (host_resp_o),
    .int_req_o   (int_req),
    .int_resp_i  (int_resp)
  );

  soc_bus i_soc_bus (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .req_i     (int_req),
    .resp_o    (int_resp),
    .l2_req_o  (l2_req),
    .l2_resp_i (l2_resp),
    .cl_req_o  (cl_req),
    .cl_resp_i (cl_resp)
  );

  l2_mem i_l2_mem (
    .clk_i  (clk_i),
    .rst_i  (rst_i),
    .req_i  (l2_req),
    .resp_o (l2_resp)
  );

  for (genvar i = 0; i < soc_pkg::N_CLUSTERS; i++) begin : gen_clusters
    cluster_unit i_cluster (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .req_i      (cl_req[i]),
      .resp_o     (cl_resp[i]),
      .fetch_en_i (cl_fetch_en_i[i]),
      .busy_o     (cl_busy_o[i]),
      .eoc_o      (cl_eoc_o[i])
    );
  end

endmodule

// File: src/cluster_unit.sv
/*
 * cluster_unit: cluster model with WORK_LEN and STATUS registers
 * runs for WORK_LEN cycles after a fetch-enable rising edge
 */

`timescale 1ns/1ps

module cluster_unit (
  input  logic               clk_i,
  input  logic               rst_i,
  input  soc_pkg::int_req_t  req_i,
  output soc_pkg::int_resp_t resp_o,
  input  logic               fetch_en_i,
  output logic               busy_o,
  output logic               eoc_o
);

  logic [soc_pkg::WORK_LEN_W-1:0] work_len_q;
  logic [soc_pkg::WORK_LEN_W-1:0] cnt_q;
  logic                           fetch_en_q;
  logic                           busy_q;
  logic                           eoc_q;
  logic                           start;
  logic [soc_pkg::REG_IDX_W-1:0]  reg_idx;

  assign start   = fetch_en_i & ~fetch_en_q;
  assign reg_idx = req_i.addr[soc_pkg::WORD_LSB +: soc_pkg::REG_IDX_W];

  // run control
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      fetch_en_q <= 1'b0;
      busy_q     <= 1'b0;
      eoc_q      <= 1'b0;
      cnt_q      <= '0;
    end else begin
      fetch_en_q <= fetch_en_i;
      if (start) begin
        // zero length runs for one cycle
        cnt_q  <= (work_len_q == '0) ? soc_pkg::WORK_LEN_W'(1) : work_len_q;
        busy_q <= 1'b1;
        eoc_q  <= 1'b0;
      end else if (busy_q) begin
        if (cnt_q == soc_pkg::WORK_LEN_W'(1)) begin
          busy_q <= 1'b0;
          eoc_q  <= 1'b1;
        end else begin
          cnt_q <= cnt_q - 1'b1;
        end
      end
    end
  end

  // register writes, STATUS is read only
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      work_len_q <= soc_pkg::WORK_LEN_W'(1);
    end else if (req_i.valid && req_i.we && reg_idx == soc_pkg::REG_WORK_LEN) begin
      work_len_q <= req_i.wdata[soc_pkg::WORK_LEN_W-1:0];
    end
  end

  always_ff @(posedge clk_i) begin
    resp_o.valid <= req_i.valid;
    resp_o.id    <= req_i.id;
    resp_o.err   <= (reg_idx != soc_pkg::REG_WORK_LEN) && (reg_idx != soc_pkg::REG_STATUS);
    if (req_i.we || reg_idx == soc_pkg::REG_WORK_LEN) begin
      resp_o.rdata <= req_i.we ? '0 : soc_pkg::DATA_W'(work_len_q);
    end else if (reg_idx == soc_pkg::REG_STATUS) begin
      resp_o.rdata <= {{(soc_pkg::DATA_W-2){1'b0}}, eoc_q, busy_q};
    end else begin
      resp_o.rdata <= '0;
    end
    if (rst_i) begin
      resp_o.valid <= 1'b0;
    end
  end

  assign busy_o = busy_q;
  assign eoc_o  = eoc_q;

endmodule

// File: src/l2_mem.sv
/*
 * l2_mem: word-addressed scratchpad
 * one-cycle registered response, ID echoed back
 */

`timescale 1ns/1ps

module l2_mem (
  input  logic               clk_i,
  input  logic               rst_i,
  input  soc_pkg::int_req_t  req_i,
  output soc_pkg::int_resp_t resp_o
);

  logic [soc_pkg::DATA_W-1:0]   mem [soc_pkg::L2_WORDS];
  logic [soc_pkg::L2_IDX_W-1:0] word_idx;

  assign word_idx = req_i.addr[soc_pkg::WORD_LSB +: soc_pkg::L2_IDX_W];

  always_ff @(posedge clk_i) begin
    if (req_i.valid && req_i.we) begin
      mem[word_idx] <= req_i.wdata;
    end
  end

  // writes answer with zero data
  always_ff @(posedge clk_i) begin
    resp_o.valid <= req_i.valid;
    resp_o.err   <= 1'b0;
    resp_o.rdata <= req_i.we ? '0 : mem[word_idx];
    resp_o.id    <= req_i.id;
    if (rst_i) begin
      resp_o.valid <= 1'b0;
    end
  end

endmodule

// File: src/soc_bus.sv
/*
 * soc_bus: address decode, target strobes and response merge
 * unmapped requests are answered here with a registered error
 */

`timescale 1ns/1ps

module soc_bus (
  input  logic                                           clk_i,
  input  logic                                           rst_i,
  input  soc_pkg::int_req_t                              req_i,
  output soc_pkg::int_resp_t                             resp_o,
  output soc_pkg::int_req_t                              l2_req_o,
  input  soc_pkg::int_resp_t                             l2_resp_i,
  output soc_pkg::int_req_t  [soc_pkg::N_CLUSTERS-1:0]   cl_req_o,
  input  soc_pkg::int_resp_t [soc_pkg::N_CLUSTERS-1:0]   cl_resp_i
);

  logic                            hit_l2;
  logic                            in_cl_win;
  logic                            hit_cl;
  logic [soc_pkg::CL_IDX_W-1:0]    cl_sel;
  logic [soc_pkg::REG_IDX_W-1:0]   reg_idx;

  soc_pkg::int_resp_t err_d;
  soc_pkg::int_resp_t err_q;

  // decode against the address map
  always_comb begin
    cl_sel    = req_i.addr[soc_pkg::CL_IDX_BIT +: soc_pkg::CL_IDX_W];
    reg_idx   = req_i.addr[soc_pkg::WORD_LSB +: soc_pkg::REG_IDX_W];
    hit_l2    = (req_i.addr & ~soc_pkg::L2_MASK) == soc_pkg::L2_BASE;
    in_cl_win = (req_i.addr & ~soc_pkg::CL_MASK) == soc_pkg::CL_BASE;
    // reserved register offsets count as unmapped
    hit_cl    = in_cl_win &&
                ((reg_idx == soc_pkg::REG_WORK_LEN) || (reg_idx == soc_pkg::REG_STATUS));
  end

  // every target sees the payload, only the selected one gets valid
  always_comb begin
    l2_req_o       = req_i;
    l2_req_o.valid = req_i.valid & hit_l2;
    for (int i = 0; i < soc_pkg::N_CLUSTERS; i++) begin
      cl_req_o[i]       = req_i;
      cl_req_o[i].valid = req_i.valid & hit_cl & (cl_sel == soc_pkg::CL_IDX_W'(i));
    end
  end

  // error answer, delayed one cycle to line up with the targets
  always_comb begin
    err_d.valid = req_i.valid & ~hit_l2 & ~hit_cl;
    err_d.err   = 1'b1;
    err_d.rdata = '0;
    err_d.id    = req_i.id;
  end

  always_ff @(posedge clk_i) begin
    err_q <= err_d;
    if (rst_i) begin
      err_q.valid <= 1'b0;
    end
  end

  // at most one source is valid in a cycle
  always_comb begin
    resp_o = err_q;
    if (l2_resp_i.valid) begin
      resp_o = l2_resp_i;
    end
    for (int i = 0; i < soc_pkg::N_CLUSTERS; i++) begin
      if (cl_resp_i[i].valid) begin
        resp_o = cl_resp_i[i];
      end
    end
  end

endmodule

// File: src/id_remap.sv
/*
 * id_remap: swaps wide host IDs for narrow internal IDs
 * registered request and response stages around an ID table
 */

`timescale 1ns/1ps

module id_remap (
  input  logic                clk_i,
  input  logic                rst_i,
  input  soc_pkg::host_req_t  host_req_i,
  output soc_pkg::host_resp_t host_resp_o,
  output soc_pkg::int_req_t   int_req_o,
  input  soc_pkg::int_resp_t  int_resp_i
);

  // table state, one entry per internal ID
  logic [soc_pkg::N_IDS-1:0]     used_q;
  logic [soc_pkg::HOST_ID_W-1:0] host_id_q [soc_pkg::N_IDS];

  logic [soc_pkg::INT_ID_W-1:0] free_idx;
  logic                         free_found;
  logic                         alloc;

  soc_pkg::int_req_t   int_req_d;
  soc_pkg::host_resp_t host_resp_d;

  // lowest free entry wins, so scan from the top down
  always_comb begin
    free_found = 1'b0;
    free_idx   = '0;
    for (int i = soc_pkg::N_IDS - 1; i >= 0; i--) begin
      if (!used_q[i]) begin
        free_found = 1'b1;
        free_idx   = soc_pkg::INT_ID_W'(i);
      end
    end
  end

  assign alloc = host_req_i.valid & free_found;

  // entry being freed this cycle is still marked used, so no clash
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      used_q <= '0;
    end else begin
      if (int_resp_i.valid) begin
        used_q[int_resp_i.id] <= 1'b0;
      end
      if (alloc) begin
        used_q[free_idx] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (alloc) begin
      host_id_q[free_idx] <= host_req_i.id;
    end
  end

  // request direction
  always_comb begin
    int_req_d.valid = alloc;
    int_req_d.we    = host_req_i.we;
    int_req_d.addr  = host_req_i.addr;
    int_req_d.wdata = host_req_i.wdata;
    int_req_d.id    = free_idx;
  end

  // response direction, restore the host ID
  always_comb begin
    host_resp_d.valid = int_resp_i.valid;
    host_resp_d.err   = int_resp_i.err;
    host_resp_d.rdata = int_resp_i.rdata;
    host_resp_d.id    = host_id_q[int_resp_i.id];
  end

  always_ff @(posedge clk_i) begin
    int_req_o   <= int_req_d;
    host_resp_o <= host_resp_d;
    if (rst_i) begin
      int_req_o.valid   <= 1'b0;
      host_resp_o.valid <= 1'b0;
    end
  end

endmodule

// File: src/soc_pkg.sv
/*
 * shared widths, address map and register offsets
 * request and response structs for the host and internal sides
 */

package soc_pkg;

  // widths and sizes
  localparam int unsigned ADDR_W     = 16;
  localparam int unsigned DATA_W     = 32;
  localparam int unsigned HOST_ID_W  = 8;
  localparam int unsigned INT_ID_W   = 2;
  localparam int unsigned N_IDS      = 4;
  localparam int unsigned N_CLUSTERS = 2;
  localparam int unsigned L2_WORDS   = 256;
  localparam int unsigned L2_IDX_W   = $clog2(L2_WORDS);
  localparam int unsigned WORD_LSB   = 2;

  // address map
  localparam logic [ADDR_W-1:0] L2_BASE = 16'h0000;
  localparam logic [ADDR_W-1:0] L2_MASK = 16'h03FF;
  localparam logic [ADDR_W-1:0] CL_BASE = 16'h1000;
  localparam logic [ADDR_W-1:0] CL_MASK = 16'h001F;

  // cluster window layout
  localparam int unsigned CL_IDX_BIT = 4;
  localparam int unsigned CL_IDX_W   = $clog2(N_CLUSTERS);
  localparam int unsigned REG_IDX_W  = 2;
  localparam logic [REG_IDX_W-1:0] REG_WORK_LEN = 2'd0;
  localparam logic [REG_IDX_W-1:0] REG_STATUS   = 2'd1;
  localparam int unsigned WORK_LEN_W = 16;

  typedef struct packed {
    logic                 valid;
    logic                 we;
    logic [ADDR_W-1:0]    addr;
    logic [DATA_W-1:0]    wdata;
    logic [HOST_ID_W-1:0] id;
  } host_req_t;

  typedef struct packed {
    logic                 valid;
    logic                 err;
    logic [DATA_W-1:0]    rdata;
    logic [HOST_ID_W-1:0] id;
  } host_resp_t;

  typedef struct packed {
    logic                valid;
    logic                we;
    logic [ADDR_W-1:0]   addr;
    logic [DATA_W-1:0]   wdata;
    logic [INT_ID_W-1:0] id;
  } int_req_t;

  typedef struct packed {
    logic                valid;
    logic                err;
    logic [DATA_W-1:0]   rdata;
    logic [INT_ID_W-1:0] id;
  } int_resp_t;

endpackage
